/* merge_data_cfg.svh */
// Build constants for the merge engine
// Included by the package and by every module that sizes ports or FIFOs
`ifndef MERGE_DATA_CFG_SVH
`define MERGE_DATA_CFG_SVH

// Engine lanes feeding one merge
`define MD_NUM_LANES 4

// Packet fields
`define MD_DATA_W 32
`define MD_TAG_W 8

// Entries in every lane FIFO and in the output FIFO
`define MD_FIFO_DEPTH 16

// Fill level that raises prog_full, leaves headroom for
// the register stages in front of each FIFO
`define MD_PROG_THRESH 12

// Merge count field of the configuration word
`define MD_COUNT_W 20

`endif

/* merge_data_pkg.sv */
// Packet and configuration types shared by the merge engine modules
// Referenced with scoped names, never imported
`include "merge_data_cfg.svh"

package merge_data_pkg;

    // -------------------------------------------------------------------
    // Packets
    // -------------------------------------------------------------------

    // FIFO storage word
    typedef struct packed {
        logic [`MD_TAG_W-1:0]  tag;
        logic [`MD_DATA_W-1:0] data;
    } packet_payload_t;

    // Used on every packet port
    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } memory_packet_t;

    // -------------------------------------------------------------------
    // Configuration
    // -------------------------------------------------------------------

    // Lane mask sits in the top bits of the memory data word
    typedef struct packed {
        logic [`MD_NUM_LANES-1:0] lane_mask;
        logic [`MD_TAG_W-1:0]     out_tag;
        logic [`MD_COUNT_W-1:0]   merge_count;
    } merge_config_t;

    // Same memory data word seen raw or as decoded fields
    typedef union packed {
        logic [`MD_DATA_W-1:0] raw;
        merge_config_t         cfg;
    } config_word_u;

endpackage

/* merge_fifo.sv */
// Synchronous FIFO with first-word-fall-through head and programmable full
// Used for every engine lane and for the request output
`timescale 1ns/1ps
`include "merge_data_cfg.svh"

module merge_fifo #(
    parameter int DEPTH       = `MD_FIFO_DEPTH,
    parameter int PROG_THRESH = `MD_PROG_THRESH
) (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    input  merge_data_pkg::packet_payload_t din,
    input  logic                            wr_en,
    input  logic                            rd_en,
    output merge_data_pkg::packet_payload_t dout,
    output logic                            valid,
    output logic                            full,
    output logic                            prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    merge_data_pkg::packet_payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    // Writes while full and reads while empty are dropped
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & valid;

    // -------------------------------------------------------------------
    // Storage
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // -------------------------------------------------------------------
    // Pointers and fill counter
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue shows without a read
    assign dout      = mem[rd_ptr];
    assign valid     = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

endmodule

/* merge_config.sv */
// Captures the configuration word from the memory response port
// Decoded fields stay frozen while the generator runs
`timescale 1ns/1ps

module merge_config (
    input  logic                           ap_clk,
    input  logic                           areset_csr_engine,
    input  merge_data_pkg::memory_packet_t response_memory,
    input  logic                           busy,
    output merge_data_pkg::merge_config_t  config_out,
    output logic                           cfg_valid
);

    merge_data_pkg::config_word_u config_word;
    logic                         capture;

    // Memory data word viewed as configuration fields
    assign config_word.raw = response_memory.payload.data;

    // Words arriving during a run are dropped
    assign capture = response_memory.valid & ~busy;

    // -------------------------------------------------------------------
    // Configuration state
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_valid <= 1'b0;
        end else if (capture) begin
            cfg_valid <= 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (capture) begin
            config_out <= config_word.cfg;
        end
    end

endmodule

/* merge_generator.sv */
// Merge control: start and done, lane gathering, summing, output push
// Pops one packet from each enabled lane per merge and pushes their sum
`timescale 1ns/1ps
`include "merge_data_cfg.svh"

module merge_generator (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    input  logic                            start,
    input  merge_data_pkg::merge_config_t   config_in,
    input  logic                            cfg_valid,
    input  merge_data_pkg::packet_payload_t lane_head [`MD_NUM_LANES],
    input  logic [`MD_NUM_LANES-1:0]        lane_valid,
    input  logic                            out_prog_full,
    output logic [`MD_NUM_LANES-1:0]        lane_pop,
    output merge_data_pkg::memory_packet_t  push,
    output logic                            busy,
    output logic                            done
);

    // Run configuration latched at start
    logic [`MD_NUM_LANES-1:0] lane_mask_q;
    logic [`MD_TAG_W-1:0]     out_tag_q;
    logic [`MD_COUNT_W-1:0]   remaining;

    logic                     start_run;
    logic                     lanes_ready;
    logic                     fire;
    logic                     finish;
    logic [`MD_DATA_W-1:0]    lane_sum;

    // -------------------------------------------------------------------
    // Control decode
    // -------------------------------------------------------------------
    assign start_run = start & cfg_valid & ~busy;

    // Masked lanes count as ready
    assign lanes_ready = &(lane_valid | ~lane_mask_q);

    assign fire = busy & lanes_ready & ~out_prog_full & (remaining != '0);

    // Last push is in the register once the count hits zero
    assign finish = busy & (remaining == '0);

    assign lane_pop = {`MD_NUM_LANES{fire}} & lane_mask_q;

    // Add the data words of enabled lanes, wraps modulo 2^32
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `MD_NUM_LANES; i++) begin
            if (lane_mask_q[i]) begin
                lane_sum = lane_sum + lane_head[i].data;
            end
        end
    end

    // -------------------------------------------------------------------
    // Run state
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            busy      <= 1'b0;
            done      <= 1'b1;
            remaining <= '0;
        end else begin
            if (start_run) begin
                busy      <= 1'b1;
                done      <= 1'b0;
                remaining <= config_in.merge_count;
            end else if (finish) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (fire) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (start_run) begin
            lane_mask_q <= config_in.lane_mask;
            out_tag_q   <= config_in.out_tag;
        end
    end

    // -------------------------------------------------------------------
    // Output packet, pushed the cycle after the merge fires
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            push.valid <= 1'b0;
        end else begin
            push.valid <= fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fire) begin
            push.payload.tag  <= out_tag_q;
            push.payload.data <= lane_sum;
        end
    end

endmodule

/* engine_merge_data.sv */
// Merge engine top: registers all ports, buffers lanes and requests in FIFOs
// Configuration word on the memory port, then a descriptor strobe starts a run
`timescale 1ns/1ps
`include "merge_data_cfg.svh"

module engine_merge_data (
    input  logic                           ap_clk,
    input  logic                           areset_csr_engine,
    input  logic                           descriptor_valid,
    input  merge_data_pkg::memory_packet_t response_engine_in [`MD_NUM_LANES],
    input  merge_data_pkg::memory_packet_t response_memory_in,
    input  logic                           request_ready,
    output logic [`MD_NUM_LANES-1:0]       lane_prog_full,
    output merge_data_pkg::memory_packet_t request_engine_out,
    output logic                           done_out
);

    logic areset_local;

    // Registered inputs
    merge_data_pkg::memory_packet_t  response_engine_in_reg [`MD_NUM_LANES];
    merge_data_pkg::memory_packet_t  response_memory_in_reg;
    logic                            descriptor_valid_reg;
    logic                            request_ready_reg;

    // Lane FIFOs
    merge_data_pkg::packet_payload_t lane_head [`MD_NUM_LANES];
    logic [`MD_NUM_LANES-1:0]        lane_valid;
    logic [`MD_NUM_LANES-1:0]        lane_pop;
    logic [`MD_NUM_LANES-1:0]        lane_prog_full_int;

    // Output FIFO
    merge_data_pkg::packet_payload_t out_dout;
    logic                            out_valid;
    logic                            out_prog_full;

    // Config and generator
    merge_data_pkg::merge_config_t   config_word;
    logic                            cfg_valid;
    merge_data_pkg::memory_packet_t  gen_push;
    logic                            gen_busy;
    logic                            gen_done;

    // Local reset fanned out to every submodule
    always_ff @(posedge ap_clk) begin
        areset_local <= areset_csr_engine;
    end

    // -------------------------------------------------------------------
    // Input registers
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_local) begin
            for (int i = 0; i < `MD_NUM_LANES; i++) begin
                response_engine_in_reg[i].valid <= 1'b0;
            end
            response_memory_in_reg.valid <= 1'b0;
            descriptor_valid_reg         <= 1'b0;
            request_ready_reg            <= 1'b0;
        end else begin
            for (int i = 0; i < `MD_NUM_LANES; i++) begin
                response_engine_in_reg[i].valid <= response_engine_in[i].valid;
            end
            response_memory_in_reg.valid <= response_memory_in.valid;
            descriptor_valid_reg         <= descriptor_valid;
            request_ready_reg            <= request_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < `MD_NUM_LANES; i++) begin
            response_engine_in_reg[i].payload <= response_engine_in[i].payload;
        end
        response_memory_in_reg.payload <= response_memory_in.payload;
    end

    // -------------------------------------------------------------------
    // Output registers
    // -------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_local) begin
            request_engine_out.valid <= 1'b0;
            done_out                 <= 1'b1;
            lane_prog_full           <= '0;
        end else begin
            // A request leaves only when the head is popped
            request_engine_out.valid <= out_valid & request_ready_reg;
            done_out                 <= gen_done;
            lane_prog_full           <= lane_prog_full_int;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= out_dout;
    end

    // -------------------------------------------------------------------
    // FIFOs
    // -------------------------------------------------------------------
    for (genvar i = 0; i < `MD_NUM_LANES; i++) begin : g_lane_fifo
        merge_fifo #(
            .DEPTH       (`MD_FIFO_DEPTH),
            .PROG_THRESH (`MD_PROG_THRESH)
        ) u_lane_fifo (
            .ap_clk            (ap_clk),
            .areset_csr_engine (areset_local),
            .din               (response_engine_in_reg[i].payload),
            .wr_en             (response_engine_in_reg[i].valid),
            .rd_en             (lane_pop[i]),
            .dout              (lane_head[i]),
            .valid             (lane_valid[i]),
            .full              (),
            .prog_full         (lane_prog_full_int[i])
        );
    end

    merge_fifo #(
        .DEPTH       (`MD_FIFO_DEPTH),
        .PROG_THRESH (`MD_PROG_THRESH)
    ) u_out_fifo (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_local),
        .din               (gen_push.payload),
        .wr_en             (gen_push.valid),
        .rd_en             (request_ready_reg),
        .dout              (out_dout),
        .valid             (out_valid),
        .full              (),
        .prog_full         (out_prog_full)
    );

    // -------------------------------------------------------------------
    // Configuration and generator
    // -------------------------------------------------------------------
    merge_config u_config (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_local),
        .response_memory   (response_memory_in_reg),
        .busy              (gen_busy),
        .config_out        (config_word),
        .cfg_valid         (cfg_valid)
    );

    merge_generator u_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_local),
        .start             (descriptor_valid_reg),
        .config_in         (config_word),
        .cfg_valid         (cfg_valid),
        .lane_head         (lane_head),
        .lane_valid        (lane_valid),
        .out_prog_full     (out_prog_full),
        .lane_pop          (lane_pop),
        .push              (gen_push),
        .busy              (gen_busy),
        .done              (gen_done)
    );

endmodule

/* tb_engine_merge_data.sv */
// Directed testbench for the merge engine top level
// Drives lane packets, a configuration word and start strobes, checks every request
`timescale 1ns/1ps
`include "merge_data_cfg.svh"

module tb_engine_merge_data;

    localparam int CLK_PERIOD  = 4;
    // Cycle budgets in run order for reset, fixed, masked, back-pressure and config tests
    localparam int TEST_CYCLES = 16 + 60 + 150 + 400 + 150;

    logic                           ap_clk;
    logic                           areset_csr_engine;
    logic                           descriptor_valid;
    merge_data_pkg::memory_packet_t response_engine_in [`MD_NUM_LANES];
    merge_data_pkg::memory_packet_t response_memory_in;
    logic                           request_ready;
    logic [`MD_NUM_LANES-1:0]       lane_prog_full;
    merge_data_pkg::memory_packet_t request_engine_out;
    logic                           done_out;

    // Lane data per test and expected {tag, sum} in arrival order
    logic [`MD_DATA_W-1:0]               lane_data [`MD_NUM_LANES][64];
    logic [`MD_TAG_W+`MD_DATA_W-1:0]     exp_q [$];
    logic [31:0]                         rng_state = 32'd56;

    engine_merge_data DUT (
        .ap_clk             (ap_clk),
        .areset_csr_engine  (areset_csr_engine),
        .descriptor_valid   (descriptor_valid),
        .response_engine_in (response_engine_in),
        .response_memory_in (response_memory_in),
        .request_ready      (request_ready),
        .lane_prog_full     (lane_prog_full),
        .request_engine_out (request_engine_out),
        .done_out           (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + 2000));
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    // -------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sum of enabled lanes at one index with 32-bit wrap
    function automatic logic [`MD_DATA_W-1:0] expected_sum(input logic [3:0] mask, input int k);
        logic [`MD_DATA_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < `MD_NUM_LANES; i++) begin
            if (mask[i]) begin
                sum = sum + lane_data[i][k];
            end
        end
        return sum;
    endfunction

    task automatic fill_random(input logic [3:0] mask, input int n);
        for (int k = 0; k < n; k++) begin
            for (int i = 0; i < `MD_NUM_LANES; i++) begin
                if (mask[i]) begin
                    rng_state = xorshift32(rng_state);
                    lane_data[i][k] = rng_state;
                end
            end
        end
    endtask

    task automatic expect_results(input logic [3:0] mask, input logic [7:0] tag, input int n);
        for (int k = 0; k < n; k++) begin
            exp_q.push_back({tag, expected_sum(mask, k)});
        end
    endtask

    task automatic send_config(input logic [`MD_NUM_LANES-1:0] mask,
                               input logic [`MD_TAG_W-1:0] tag,
                               input logic [`MD_COUNT_W-1:0] count);
        @(posedge ap_clk);
        response_memory_in.valid        <= 1'b1;
        response_memory_in.payload.tag  <= '0;
        response_memory_in.payload.data <= {mask, tag, count};
        @(posedge ap_clk);
        response_memory_in.valid <= 1'b0;
        repeat (3) @(posedge ap_clk);
    endtask

    // Pulses the start strobe and expects done_out to drop within a few cycles
    task automatic start_run;
        int waited;
        @(posedge ap_clk);
        descriptor_valid <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        waited = 0;
        while (done_out === 1'b1 && waited < 8) begin
            @(negedge ap_clk);
            waited++;
        end
        check_value("done_out", 64'(done_out), 64'd0);
    endtask

    // Producer that honours lane_prog_full and may release request_ready once it is seen
    task automatic drive_lanes(input logic [3:0] mask, input int n, input bit hold_ready);
        int                       sent [`MD_NUM_LANES];
        bit                       seen_full;
        bit                       all_sent;
        logic [`MD_NUM_LANES-1:0] pf;
        seen_full = 1'b0;
        all_sent  = 1'b0;
        for (int i = 0; i < `MD_NUM_LANES; i++) begin
            sent[i] = 0;
        end
        while (!all_sent) begin
            @(negedge ap_clk);
            pf = lane_prog_full;
            if (pf != '0) begin
                seen_full = 1'b1;
            end
            @(posedge ap_clk);
            all_sent = 1'b1;
            for (int i = 0; i < `MD_NUM_LANES; i++) begin
                if (mask[i] && sent[i] < n && !pf[i]) begin
                    response_engine_in[i].valid        <= 1'b1;
                    response_engine_in[i].payload.tag  <= 8'(i);
                    response_engine_in[i].payload.data <= lane_data[i][sent[i]];
                    sent[i] = sent[i] + 1;
                end else begin
                    response_engine_in[i].valid <= 1'b0;
                end
                if (mask[i] && sent[i] < n) begin
                    all_sent = 1'b0;
                end
            end
            if (hold_ready && seen_full) begin
                request_ready <= 1'b1;
            end
        end
        @(posedge ap_clk);
        for (int i = 0; i < `MD_NUM_LANES; i++) begin
            response_engine_in[i].valid <= 1'b0;
        end
        if (hold_ready) begin
            request_ready <= 1'b1;
            check_value("lane_prog_full seen", 64'(seen_full), 64'd1);
        end
    endtask

    task automatic wait_for_results;
        while (exp_q.size() != 0 || done_out !== 1'b1) begin
            @(negedge ap_clk);
        end
        // Room for a stray extra request to show up
        repeat (4) @(negedge ap_clk);
    endtask

    // Every request is compared in order against the queue
    always @(negedge ap_clk) begin
        logic [`MD_TAG_W+`MD_DATA_W-1:0] exp_pkt;
        if (request_engine_out.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A request appeared on request_engine_out with no result expected");
                $display("SOME TESTS FAILED");
                $fatal(1, "Unexpected request");
            end else begin
                exp_pkt = exp_q.pop_front();
                check_value("request_engine_out.tag", 64'(request_engine_out.payload.tag),
                            64'(exp_pkt[`MD_TAG_W+`MD_DATA_W-1:`MD_DATA_W]));
                check_value("request_engine_out.data", 64'(request_engine_out.payload.data),
                            64'(exp_pkt[`MD_DATA_W-1:0]));
            end
        end
    end

    // -------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------
    task automatic test_after_reset;
        @(negedge ap_clk);
        check_value("done_out", 64'(done_out), 64'd1);
        check_value("request_engine_out.valid", 64'(request_engine_out.valid), 64'd0);
        check_value("lane_prog_full", 64'(lane_prog_full), 64'd0);
    endtask

    task automatic test_all_lanes_fixed;
        // Large words so the sums wrap
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < `MD_NUM_LANES; i++) begin
                lane_data[i][k] = 32'h4000_0001 * 32'(i + 1) + 32'h0101_0101 * 32'(k);
            end
        end
        send_config(4'hF, 8'h5A, 20'd3);
        expect_results(4'hF, 8'h5A, 3);
        start_run();
        drive_lanes(4'hF, 3, 1'b0);
        wait_for_results();
    endtask

    task automatic test_masked_random;
        fill_random(4'h5, 16);
        send_config(4'h5, 8'h33, 20'd16);
        expect_results(4'h5, 8'h33, 16);
        start_run();
        drive_lanes(4'h5, 16, 1'b0);
        wait_for_results();
    endtask

    task automatic test_back_pressure;
        fill_random(4'hF, 40);
        @(posedge ap_clk);
        request_ready <= 1'b0;
        send_config(4'hF, 8'hC3, 20'd40);
        expect_results(4'hF, 8'hC3, 40);
        start_run();
        drive_lanes(4'hF, 40, 1'b1);
        wait_for_results();
    endtask

    task automatic test_config_during_run;
        fill_random(4'h3, 4);
        send_config(4'h3, 8'h71, 20'd4);
        expect_results(4'h3, 8'h71, 4);
        start_run();
        // Arrives while busy and must not touch this run
        send_config(4'hC, 8'h9E, 20'd5);
        drive_lanes(4'h3, 4, 1'b0);
        wait_for_results();
        fill_random(4'hC, 5);
        send_config(4'hC, 8'h9E, 20'd5);
        expect_results(4'hC, 8'h9E, 5);
        start_run();
        drive_lanes(4'hC, 5, 1'b0);
        wait_for_results();
    endtask

    initial begin
        areset_csr_engine  = 1'b1;
        descriptor_valid   = 1'b0;
        response_memory_in = '0;
        request_ready      = 1'b1;
        for (int i = 0; i < `MD_NUM_LANES; i++) begin
            response_engine_in[i] = '0;
        end
        repeat (16) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        repeat (3) @(posedge ap_clk);

        test_after_reset();
        test_all_lanes_fixed();
        test_masked_random();
        test_back_pressure();
        test_config_during_run();

        if (exp_q.size() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
merge_data_pkg.sv
merge_fifo.sv
merge_config.sv
merge_generator.sv
engine_merge_data.sv
tb_engine_merge_data.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the merge engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_engine_merge_data \
    -o tb_sim > sim.log 2>&1 && ./obj_dir/tb_sim >> sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log
if grep -q "SOME TESTS FAILED" sim.log || grep -q "exited with an error" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
